/* edram_remap.f */
logic/edram_pkg.sv
logic/request_stage.sv
logic/bank_array.sv
logic/remap_table.sv
logic/read_merge.sv
logic/edram_remap_top.sv
tests/edram_remap_properties.sv
tests/tb_edram_remap.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal \
  -f edram_remap.f --top-module tb_edram_remap \
  -o tb_edram_remap > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/tb_edram_remap > "$SIM_LOG" 2>&1 \
  || { echo "Build or simulation failed, see $BUILD_LOG and $SIM_LOG"; exit 1; }

grep -q "^TEST PASS$" "$SIM_LOG" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see $SIM_LOG"; exit 1; }

/* tests/tb_edram_remap.sv */
`timescale 1ns/100ps

module tb_edram_remap;

  localparam int WIDTH      = edram_pkg::DEF_WIDTH;
  localparam int NUMVBNK    = edram_pkg::DEF_NUMVBNK;
  localparam int NUMVROW    = edram_pkg::DEF_NUMVROW;
  localparam int NUMADDR    = NUMVBNK * NUMVROW;
  localparam int BITADDR    = $clog2(NUMADDR);
  localparam int BITVBNK    = $clog2(NUMVBNK);
  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 10;
  localparam int DIR_CYCLES = 200;   // Upper bound for the directed part.
  localparam int N_RANDOM   = 3000;
  localparam int DRAIN      = 10;
  localparam int TIMEOUT    = RST_CYCLES + DIR_CYCLES + N_RANDOM + DRAIN + 100;

  logic               clk;
  logic               rst;
  logic               vread;
  logic               vwrite;
  logic [BITADDR-1:0] vaddr;
  logic [WIDTH-1:0]   vdin;
  logic               refr;
  logic [BITVBNK-1:0] refr_bank;
  logic               vread_vld;
  logic [WIDTH-1:0]   vdout;
  logic               vread_remap;

  // Reference model state.
  logic [WIDTH-1:0] mdl_bank  [NUMVBNK][NUMVROW];
  logic [WIDTH-1:0] mdl_cache [NUMVROW];
  logic             mdl_vld   [NUMVROW];
  int               mdl_bnk   [NUMVROW];
  logic             written   [NUMADDR];

  logic [WIDTH-1:0] exp_data_q  [$];
  logic             exp_remap_q [$];

  logic [31:0] rng = 32'hff20;
  logic        rd_d1 = 1'b0;
  logic        rd_d2 = 1'b0;
  int          data_errs = 0;
  int          flag_errs = 0;
  int          timing_errs = 0;
  int          other_errs = 0;
  int          reads_checked = 0;

  edram_remap_top #(.WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW)) u_dut (
    .clk         (clk),
    .rst         (rst),
    .vread       (vread),
    .vwrite      (vwrite),
    .vaddr       (vaddr),
    .vdin        (vdin),
    .refr        (refr),
    .refr_bank   (refr_bank),
    .vread_vld   (vread_vld),
    .vdout       (vdout),
    .vread_remap (vread_remap)
  );

  bind edram_remap_top edram_remap_properties #(
    .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW)
  ) u_properties (
    .clk       (clk),
    .rst       (rst),
    .vread     (vread),
    .vwrite    (vwrite),
    .vaddr     (vaddr),
    .refr      (refr),
    .refr_bank (refr_bank),
    .vread_vld (vread_vld)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Applies one request to the model; reads push their expected result.
  function automatic void model_request(input logic rd, input logic wr, input int addr,
                                        input logic [WIDTH-1:0] data, input logic conflict);
    int b;
    int r;
    b = addr % NUMVBNK;
    r = addr / NUMVBNK;
    if (wr) begin
      if (mdl_vld[r] && mdl_bnk[r] == b) begin
        mdl_cache[r] = data;  // Cache hit.
      end else if (conflict) begin
        if (mdl_vld[r]) begin
          mdl_bank[mdl_bnk[r]][r] = mdl_cache[r];  // Evict to the owner bank.
        end
        mdl_cache[r] = data;
        mdl_vld[r]   = 1'b1;
        mdl_bnk[r]   = b;
      end else begin
        mdl_bank[b][r] = data;
      end
    end else if (rd) begin
      if (mdl_vld[r] && mdl_bnk[r] == b) begin
        exp_data_q.push_back(mdl_cache[r]);
        exp_remap_q.push_back(1'b1);
      end else begin
        exp_data_q.push_back(mdl_bank[b][r]);
        exp_remap_q.push_back(1'b0);
      end
    end
  endfunction

  task automatic drive_op(input logic rd, input logic wr, input int addr,
                          input logic [WIDTH-1:0] data, input logic rf, input int rf_bank);
    logic conflict;
    conflict = rf && (rf_bank == addr % NUMVBNK);
    @(posedge clk);
    vread     <= rd;
    vwrite    <= wr;
    vaddr     <= BITADDR'(addr);
    vdin      <= data;
    refr      <= rf;
    refr_bank <= BITVBNK'(rf_bank);
    model_request(rd, wr, addr, data, conflict);
    if (wr) begin
      written[addr] = 1'b1;
    end
  endtask

  task automatic write_word(input int addr, input logic [WIDTH-1:0] data, input logic rf,
                            input int rf_bank);
    drive_op(1'b0, 1'b1, addr, data, rf, rf_bank);
  endtask

  task automatic read_word(input int addr);
    drive_op(1'b1, 1'b0, addr, '0, 1'b0, 0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_op(1'b0, 1'b0, 0, '0, 1'b0, 0);
  endtask

  // Outputs are sampled mid-cycle, well away from the driving edge.
  always @(negedge clk) begin : compare
    logic [WIDTH-1:0] exp_data;
    logic             exp_remap;
    if (!rst) begin
      assert (vread_vld === rd_d2) else begin
        $display("FAIL t=%0t vread_vld expected %b got %b", $time, rd_d2, vread_vld);
        timing_errs++;
      end
      if (vread_vld === 1'b1) begin
        assert (exp_data_q.size() > 0) else begin
          $display("Read result at t=%0t arrived with no read outstanding", $time);
          other_errs++;
        end
        if (exp_data_q.size() > 0) begin
          exp_data  = exp_data_q.pop_front();
          exp_remap = exp_remap_q.pop_front();
          reads_checked++;
          assert (vdout === exp_data) else begin
            $display("FAIL t=%0t vdout expected %h got %h", $time, exp_data, vdout);
            data_errs++;
          end
          assert (vread_remap === exp_remap) else begin
            $display("FAIL t=%0t vread_remap expected %b got %b", $time, exp_remap,
                     vread_remap);
            flag_errs++;
          end
        end
      end
    end
    rd_d2 = rd_d1;
    rd_d1 = vread;
  end

  initial begin : watchdog
    #(TIMEOUT * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] r;
    int          addr;
    int          rfb;
    int          total;
    rst       = 1'b1;
    vread     = 1'b0;
    vwrite    = 1'b0;
    vaddr     = '0;
    vdin      = '0;
    refr      = 1'b0;
    refr_bank = '0;
    for (int i = 0; i < NUMVROW; i++) begin
      mdl_vld[i] = 1'b0;
      mdl_bnk[i] = 0;
    end
    for (int i = 0; i < NUMADDR; i++) begin
      written[i] = 1'b0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // Idle, then plain writes and reads of rows 0 and 1.
    idle_cycles(5);
    for (int i = 0; i < 12; i++) begin
      write_word(i, 32'ha5a5_0000 | i, 1'b0, 0);
    end
    idle_cycles(2);
    for (int i = 0; i < 12; i++) begin
      read_word(i);
    end
    idle_cycles(3);

    // Address 14 is bank 2, row 2; refresh on bank 2 diverts it.
    write_word(14, 32'hd1e7_0014, 1'b1, 2);
    idle_cycles(1);
    read_word(14);
    write_word(14, 32'hc0de_0014, 1'b0, 0);  // Hit without refresh.
    read_word(14);
    // Address 17 is bank 5, row 2; diverting it evicts address 14.
    write_word(17, 32'hbeef_0017, 1'b1, 5);
    read_word(14);
    read_word(17);
    idle_cycles(2);

    // Back-to-back traffic including a read right after a write.
    write_word(30, 32'h1111_0030, 1'b0, 0);
    read_word(30);
    write_word(30, 32'h2222_0030, 1'b1, 0);
    read_word(30);
    write_word(31, 32'h3333_0031, 1'b1, 1);
    write_word(30, 32'h4444_0030, 1'b1, 0);
    read_word(31);
    read_word(30);
    idle_cycles(3);

    // Random mix with refresh conflicts on writes and reads.
    for (int n = 0; n < N_RANDOM; n++) begin
      rng  = xorshift(rng);
      r    = rng;
      addr = int'(r[31:8]) % NUMADDR;
      rfb  = r[4] ? addr % NUMVBNK : int'(r[7:5]) % NUMVBNK;
      rng  = xorshift(rng);
      if (r[2:0] < 3'd4) begin
        write_word(addr, WIDTH'(rng), r[3], rfb);
      end else if (r[2:0] < 3'd7 && written[addr]) begin
        drive_op(1'b1, 1'b0, addr, '0, r[3], rfb);  // Refresh must not disturb reads.
      end else begin
        drive_op(1'b0, 1'b0, addr, '0, r[3], rfb);
      end
    end
    idle_cycles(DRAIN);

    assert (exp_data_q.size() == 0) else begin
      $display("%0d reads were never answered", exp_data_q.size());
      other_errs++;
    end
    total = data_errs + flag_errs + timing_errs + other_errs;
    $display("Errors: data %0d, remap %0d, timing %0d, other %0d (reads checked %0d)",
             data_errs, flag_errs, timing_errs, other_errs, reads_checked);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tests/edram_remap_properties.sv */
`timescale 1ns/100ps

module edram_remap_properties #(
  parameter int NUMVBNK = 6,
  parameter int NUMVROW = 16
) (
  input logic                               clk,
  input logic                               rst,
  input logic                               vread,
  input logic                               vwrite,
  input logic [$clog2(NUMVBNK*NUMVROW)-1:0] vaddr,
  input logic                               refr,
  input logic [$clog2(NUMVBNK)-1:0]         refr_bank,
  input logic                               vread_vld
);

  localparam int NUMADDR = NUMVBNK * NUMVROW;

  // Strobes are mutually exclusive.
  a_one_strobe : assert property (@(posedge clk) disable iff (rst)
    !(vread && vwrite))
    else $error("Read and write strobes were high in the same cycle.");

  a_addr_range : assert property (@(posedge clk) disable iff (rst)
    (vread || vwrite) |-> (32'(vaddr) < NUMADDR))
    else $error("Access address is beyond the virtual address space.");

  a_refr_range : assert property (@(posedge clk) disable iff (rst)
    refr |-> (32'(refr_bank) < NUMVBNK))
    else $error("Refresh bank number is beyond the bank count.");

  // Fixed two-cycle read latency.
  a_read_latency : assert property (@(posedge clk) disable iff (rst)
    vread |-> ##2 vread_vld)
    else $error("Read was not answered two cycles after the request.");

  a_no_stray_vld : assert property (@(posedge clk) disable iff (rst)
    $rose(vread_vld) |-> $past(vread, 2))
    else $error("Read valid rose without a read two cycles earlier.");

endmodule

/* logic/edram_remap_top.sv */
`timescale 1ns/100ps

module edram_remap_top #(
  parameter int WIDTH   = edram_pkg::DEF_WIDTH,
  parameter int NUMVBNK = edram_pkg::DEF_NUMVBNK,
  parameter int NUMVROW = edram_pkg::DEF_NUMVROW
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                vread,
  input  logic                                vwrite,
  input  logic [$clog2(NUMVBNK*NUMVROW)-1:0]  vaddr,
  input  logic [WIDTH-1:0]                    vdin,
  input  logic                                refr,
  input  logic [$clog2(NUMVBNK)-1:0]          refr_bank,
  output logic                                vread_vld,
  output logic [WIDTH-1:0]                    vdout,
  output logic                                vread_remap
);

  localparam int NUMADDR = NUMVBNK * NUMVROW;  // Flat virtual address space.
  localparam int BITADDR = $clog2(NUMADDR);
  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITVROW = $clog2(NUMVROW);

  edram_pkg::op_e     req_op;
  logic [BITVBNK-1:0] req_bank;
  logic [BITVROW-1:0] req_row;
  logic [WIDTH-1:0]   req_din;
  logic               req_conflict;
  logic               bwrite;
  logic [BITVBNK-1:0] bwr_bank;
  logic [BITVROW-1:0] bwr_row;
  logic [WIDTH-1:0]   bwr_data;
  logic [WIDTH-1:0]   bdout;
  logic               cache_hit;
  logic [WIDTH-1:0]   cdout;
  logic [BITADDR-1:0] addr;

  assign addr = vaddr;

  request_stage #(.WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW)) u_request_stage (
    .clk          (clk),
    .rst          (rst),
    .vread        (vread),
    .vwrite       (vwrite),
    .vaddr        (addr),
    .vdin         (vdin),
    .refr         (refr),
    .refr_bank    (refr_bank),
    .req_op       (req_op),
    .req_bank     (req_bank),
    .req_row      (req_row),
    .req_din      (req_din),
    .req_conflict (req_conflict)
  );

  bank_array #(.WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW)) u_bank_array (
    .clk      (clk),
    .bwrite   (bwrite),
    .bwr_bank (bwr_bank),
    .bwr_row  (bwr_row),
    .bwr_data (bwr_data),
    .req_bank (req_bank),
    .req_row  (req_row),
    .bdout    (bdout)
  );

  remap_table #(.WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW)) u_remap_table (
    .clk          (clk),
    .rst          (rst),
    .req_op       (req_op),
    .req_bank     (req_bank),
    .req_row      (req_row),
    .req_din      (req_din),
    .req_conflict (req_conflict),
    .bwrite       (bwrite),
    .bwr_bank     (bwr_bank),
    .bwr_row      (bwr_row),
    .bwr_data     (bwr_data),
    .cache_hit    (cache_hit),
    .cdout        (cdout)
  );

  read_merge #(.WIDTH(WIDTH)) u_read_merge (
    .clk         (clk),
    .rst         (rst),
    .req_op      (req_op),
    .cache_hit   (cache_hit),
    .cdout       (cdout),
    .bdout       (bdout),
    .vread_vld   (vread_vld),
    .vdout       (vdout),
    .vread_remap (vread_remap)
  );

endmodule

/* logic/read_merge.sv */
`timescale 1ns/100ps

module read_merge #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  edram_pkg::op_e   req_op,
  input  logic             cache_hit,
  input  logic [WIDTH-1:0] cdout,
  input  logic [WIDTH-1:0] bdout,
  output logic             vread_vld,
  output logic [WIDTH-1:0] vdout,
  output logic             vread_remap
);

  logic             is_read;
  logic [WIDTH-1:0] merged;

  assign is_read = (req_op == edram_pkg::OP_READ);
  assign merged  = cache_hit ? cdout : bdout;  // Cache wins when the map matches.

  always_ff @(posedge clk) begin
    if (rst) begin
      vread_vld   <= 1'b0;
      vread_remap <= 1'b0;
    end else begin
      vread_vld   <= is_read;
      vread_remap <= is_read && cache_hit;
    end
  end

  // Data holds its last value between reads.
  always_ff @(posedge clk) begin
    if (is_read) begin
      vdout <= merged;
    end
  end

endmodule

/* logic/remap_table.sv */
`timescale 1ns/100ps

module remap_table #(
  parameter int WIDTH   = 32,
  parameter int NUMVBNK = 6,
  parameter int NUMVROW = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  edram_pkg::op_e             req_op,
  input  logic [$clog2(NUMVBNK)-1:0] req_bank,
  input  logic [$clog2(NUMVROW)-1:0] req_row,
  input  logic [WIDTH-1:0]           req_din,
  input  logic                       req_conflict,
  output logic                       bwrite,
  output logic [$clog2(NUMVBNK)-1:0] bwr_bank,
  output logic [$clog2(NUMVROW)-1:0] bwr_row,
  output logic [WIDTH-1:0]           bwr_data,
  output logic                       cache_hit,
  output logic [WIDTH-1:0]           cdout
);

  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITVROW = $clog2(NUMVROW);

  // One map entry and one cache word per row.
  logic               map_vld [NUMVROW];
  logic [BITVBNK-1:0] map_bnk [NUMVROW];
  logic [WIDTH-1:0]   cache   [NUMVROW];

  logic [BITVROW-1:0] row;
  logic               ent_vld;
  logic [BITVBNK-1:0] ent_bnk;
  logic [WIDTH-1:0]   ent_dat;
  logic               ent_hit;
  logic               is_read;
  logic               is_write;
  logic               divert;
  logic               evict;
  logic               cwrite;
  logic               plain_write;

  assign row     = req_row;
  assign ent_vld = map_vld[row];
  assign ent_bnk = map_bnk[row];
  assign ent_dat = cache[row];
  assign ent_hit = ent_vld && (ent_bnk == req_bank);  // Row is cached for this bank.

  assign is_read  = (req_op == edram_pkg::OP_READ);
  assign is_write = (req_op == edram_pkg::OP_WRITE);

  // Write rule.
  assign divert      = is_write && !ent_hit && req_conflict;  // Bank busy with refresh.
  assign evict       = divert && ent_vld;                     // Old word belongs elsewhere.
  assign cwrite      = is_write && (ent_hit || req_conflict);
  assign plain_write = is_write && !ent_hit && !req_conflict;

  // Eviction and a plain write never coincide, so one bank command suffices.
  assign bwrite   = evict || plain_write;
  assign bwr_bank = evict ? ent_bnk : req_bank;
  assign bwr_row  = row;
  assign bwr_data = evict ? ent_dat : req_din;

  // Read side.
  assign cache_hit = is_read && ent_hit;
  assign cdout     = ent_dat;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUMVROW; i++) begin
        map_vld[i] <= 1'b0;
      end
    end else if (divert) begin
      map_vld[row] <= 1'b1;  // Entry now owned by the diverted bank.
    end
  end

  always_ff @(posedge clk) begin
    if (divert) begin
      map_bnk[row] <= req_bank;
    end
    if (cwrite) begin
      cache[row] <= req_din;  // Hit or diversion both land here.
    end
  end

endmodule

/* logic/bank_array.sv */
`timescale 1ns/100ps

module bank_array #(
  parameter int WIDTH   = 32,
  parameter int NUMVBNK = 6,
  parameter int NUMVROW = 16
) (
  input  logic                       clk,
  input  logic                       bwrite,
  input  logic [$clog2(NUMVBNK)-1:0] bwr_bank,
  input  logic [$clog2(NUMVROW)-1:0] bwr_row,
  input  logic [WIDTH-1:0]           bwr_data,
  input  logic [$clog2(NUMVBNK)-1:0] req_bank,
  input  logic [$clog2(NUMVROW)-1:0] req_row,
  output logic [WIDTH-1:0]           bdout
);

  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITVROW = $clog2(NUMVROW);

  logic [WIDTH-1:0]   mem [NUMVBNK][NUMVROW];
  logic [BITVBNK-1:0] wr_bank;
  logic [BITVROW-1:0] wr_row;
  logic [BITVBNK-1:0] rd_bank;
  logic [BITVROW-1:0] rd_row;

  assign wr_bank = bwr_bank;
  assign wr_row  = bwr_row;
  assign rd_bank = req_bank;
  assign rd_row  = req_row;

  // Single write port, driven by the remap logic.
  always_ff @(posedge clk) begin
    if (bwrite) begin
      mem[wr_bank][wr_row] <= bwr_data;
    end
  end

  // Read is combinational on the registered request.
  assign bdout = mem[rd_bank][rd_row];

endmodule

/* logic/request_stage.sv */
`timescale 1ns/100ps

module request_stage #(
  parameter int WIDTH   = 32,
  parameter int NUMVBNK = 6,
  parameter int NUMVROW = 16
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  vread,
  input  logic                                  vwrite,
  input  logic [$clog2(NUMVBNK*NUMVROW)-1:0]    vaddr,
  input  logic [WIDTH-1:0]                      vdin,
  input  logic                                  refr,
  input  logic [$clog2(NUMVBNK)-1:0]            refr_bank,
  output edram_pkg::op_e                        req_op,
  output logic [$clog2(NUMVBNK)-1:0]            req_bank,
  output logic [$clog2(NUMVROW)-1:0]            req_row,
  output logic [WIDTH-1:0]                      req_din,
  output logic                                  req_conflict
);

  localparam int BITADDR = $clog2(NUMVBNK*NUMVROW);
  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITVROW = $clog2(NUMVROW);

  logic [BITADDR-1:0] addr_bank_full;
  logic [BITADDR-1:0] addr_row_full;
  logic [BITVBNK-1:0] addr_bank;
  logic [BITVROW-1:0] addr_row;
  logic               conflict_in;
  edram_pkg::op_e     op_in;

  // Bank count may be odd, so a true modulo and quotient are needed.
  assign addr_bank_full = BITADDR'(vaddr % NUMVBNK);
  assign addr_row_full  = BITADDR'(vaddr / NUMVBNK);
  assign addr_bank      = addr_bank_full[BITVBNK-1:0];  // Always below NUMVBNK.
  assign addr_row       = addr_row_full[BITVROW-1:0];   // Always below NUMVROW.

  // Refresh only matters when it hits the bank being written.
  assign conflict_in = refr && (refr_bank == addr_bank);

  always_comb begin
    if (vwrite) begin
      op_in = edram_pkg::OP_WRITE;
    end else if (vread) begin
      op_in = edram_pkg::OP_READ;
    end else begin
      op_in = edram_pkg::OP_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_op       <= edram_pkg::OP_IDLE;
      req_conflict <= 1'b0;
    end else begin
      req_op       <= op_in;
      req_conflict <= conflict_in;
    end
  end

  always_ff @(posedge clk) begin
    req_bank <= addr_bank;
    req_row  <= addr_row;
    req_din  <= vdin;  // Only meaningful for writes.
  end

endmodule

/* logic/edram_pkg.sv */
package edram_pkg;

  // Operation carried by the request in flight.
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,  // No request this cycle.
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } op_e;

  // Default geometry of the virtual memory.
  parameter int DEF_WIDTH   = 32;  // Data bits per word.
  parameter int DEF_NUMVBNK = 6;   // Bank count that need not be a power of two.
  parameter int DEF_NUMVROW = 16;  // Rows per bank and cache depth.

endpackage
